/* source/arch_defs_pkg.sv */
package arch_defs_pkg;

    // Bus widths
    localparam int DATA_WIDTH = 8;
    localparam int ADDR_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Index widths of each region
    localparam int RAM_ADDR_BITS  = 13;   // 8 KB
    localparam int VRAM_ADDR_BITS = 12;   // 4 KB
    localparam int ROM_ADDR_BITS  = 12;   // 4 KB
    localparam int MMIO_ADDR_BITS = 12;   // One 4 KB I/O page

    // Memory map
    localparam addr_t RAM_BASE  = 16'h0000;
    localparam addr_t VRAM_BASE = 16'hD000;
    localparam addr_t MMIO_BASE = 16'hE000;
    localparam addr_t ROM_BASE  = 16'hF000;

    // LED port inside the I/O page
    localparam logic [MMIO_ADDR_BITS-1:0] LED_OFFSET = 12'h002;

    localparam string ROM_IMAGE = "source/rom_image.hex";

endpackage

/* source/uart_defs_pkg.sv */
package uart_defs_pkg;

    // Short bit period so frames stay cheap in simulation
    localparam int CLKS_PER_BIT  = 8;
    localparam int BAUD_CNT_BITS = $clog2(CLKS_PER_BIT);

    // Register offsets, selected by address bit 0
    localparam logic UART_STATUS_OFFSET = 1'b0;
    localparam logic UART_DATA_OFFSET   = 1'b1;

    // Status register bits
    localparam int STATUS_TX_BUSY    = 0;
    localparam int STATUS_RX_VALID   = 1;
    localparam int STATUS_RX_OVERRUN = 2;

endpackage

/* source/sync_ram.sv */
`timescale 1ns/10ps

module sync_ram #(
    parameter int ADDR_BITS = 13
) (
    input  logic                  clk,
    input  logic                  we_i,
    input  logic [ADDR_BITS-1:0]  addr_i,
    input  arch_defs_pkg::data_t  data_i,
    output arch_defs_pkg::data_t  data_o
);
    import arch_defs_pkg::*;

    data_t mem [2**ADDR_BITS];
    data_t rd_data_q;

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= data_i;
        end
        rd_data_q <= mem[addr_i];   // Read before write on the same index
    end

    assign data_o = rd_data_q;

    // A write to an unknown index would corrupt an unknown location
    a_write_addr_known: assert property (@(posedge clk) we_i |-> !$isunknown(addr_i));

endmodule

/* source/boot_rom.sv */
`timescale 1ns/10ps

module boot_rom (
    input  logic                                  clk,
    input  logic [arch_defs_pkg::ROM_ADDR_BITS-1:0] addr_i,
    output arch_defs_pkg::data_t                  data_o
);
    import arch_defs_pkg::*;

    data_t rom [2**ROM_ADDR_BITS];
    data_t rd_data_q;

    // Zero fill first, the image only covers the low bytes
    initial begin
        for (int i = 0; i < 2**ROM_ADDR_BITS; i++) begin
            rom[i] = '0;
        end
        $readmemh(ROM_IMAGE, rom);
    end

    always_ff @(posedge clk) begin
        rd_data_q <= rom[addr_i];
    end

    assign data_o = rd_data_q;

endmodule

/* source/baud_timer.sv */
`timescale 1ns/10ps

module baud_timer (
    input  logic clk,
    input  logic rst_n_i,
    input  logic run_i,
    input  logic start_i,
    input  logic half_i,
    output logic bit_tick_o
);
    import uart_defs_pkg::*;

    localparam logic [BAUD_CNT_BITS-1:0] FULL_RELOAD = BAUD_CNT_BITS'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_BITS-1:0] HALF_RELOAD = BAUD_CNT_BITS'(CLKS_PER_BIT / 2 - 1);

    logic [BAUD_CNT_BITS-1:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= half_i ? HALF_RELOAD : FULL_RELOAD;
        end else if (bit_tick_o) begin
            count_q <= FULL_RELOAD;            // Next bit boundary
        end else if (run_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Tick on the last cycle of each period
    assign bit_tick_o = run_i && !start_i && (count_q == '0);

    // First tick one full or half period after a start
    a_full_period: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        start_i && !half_i |-> ##CLKS_PER_BIT (bit_tick_o || !run_i));

    a_half_period: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        start_i && half_i |-> ##(CLKS_PER_BIT / 2) (bit_tick_o || !run_i));

endmodule

/* source/uart_fsm.sv */
`timescale 1ns/10ps

module uart_fsm (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 tx_start_i,
    input  arch_defs_pkg::data_t tx_data_i,
    input  logic                 tx_tick_i,
    input  logic                 rx_tick_i,
    input  logic                 rx_i,
    output logic                 tx_o,
    output logic                 tx_busy_o,
    output logic                 tx_run_o,
    output logic                 tx_timer_start_o,
    output logic                 rx_run_o,
    output logic                 rx_timer_start_o,
    output logic                 rx_half_o,
    output logic                 rx_done_o,
    output arch_defs_pkg::data_t rx_data_o
);
    import arch_defs_pkg::*;

    localparam int IDX_BITS = $clog2(DATA_WIDTH);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_e;

    uart_state_e         tx_state_q;
    uart_state_e         rx_state_q;
    logic [IDX_BITS-1:0] tx_idx_q;
    logic [IDX_BITS-1:0] rx_idx_q;
    data_t               tx_shift_q;
    data_t               rx_shift_q;
    logic                tx_q;
    logic                rx_s1_q;
    logic                rx_s2_q;
    logic                rx_prev_q;
    logic                rx_fall;

    // Transmitter
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tx_state_q <= IDLE;
            tx_idx_q   <= '0;
            tx_q       <= 1'b1;   // Line idles high
        end else begin
            case (tx_state_q)
                IDLE: begin
                    if (tx_start_i) begin
                        tx_state_q <= START;
                        tx_q       <= 1'b0;
                    end
                end
                START: begin
                    if (tx_tick_i) begin
                        tx_state_q <= DATA;
                        tx_idx_q   <= '0;
                        tx_q       <= tx_shift_q[0];
                    end
                end
                DATA: begin
                    if (tx_tick_i) begin
                        if (tx_idx_q == IDX_BITS'(DATA_WIDTH - 1)) begin
                            tx_state_q <= STOP;
                            tx_q       <= 1'b1;
                        end else begin
                            tx_idx_q <= tx_idx_q + 1'b1;
                            tx_q     <= tx_shift_q[0];
                        end
                    end
                end
                default: begin   // STOP
                    if (tx_tick_i) begin
                        tx_state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    // Shifts once per bit, LSB out first
    always_ff @(posedge clk) begin
        if (tx_state_q == IDLE && tx_start_i) begin
            tx_shift_q <= tx_data_i;
        end else if (tx_tick_i && (tx_state_q == START || tx_state_q == DATA)) begin
            tx_shift_q <= {1'b0, tx_shift_q[DATA_WIDTH-1:1]};
        end
    end

    assign tx_o             = tx_q;
    assign tx_busy_o        = (tx_state_q != IDLE);
    assign tx_run_o         = (tx_state_q != IDLE);
    assign tx_timer_start_o = (tx_state_q == IDLE) && tx_start_i;

    // Receiver
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rx_s1_q    <= 1'b1;
            rx_s2_q    <= 1'b1;
            rx_prev_q  <= 1'b1;
            rx_state_q <= IDLE;
            rx_idx_q   <= '0;
        end else begin
            rx_s1_q   <= rx_i;
            rx_s2_q   <= rx_s1_q;
            rx_prev_q <= rx_s2_q;
            case (rx_state_q)
                IDLE: begin
                    if (rx_fall) begin
                        rx_state_q <= START;
                    end
                end
                START: begin
                    if (rx_tick_i) begin
                        rx_state_q <= rx_s2_q ? IDLE : DATA;   // Glitch, not a start bit
                        rx_idx_q   <= '0;
                    end
                end
                DATA: begin
                    if (rx_tick_i) begin
                        if (rx_idx_q == IDX_BITS'(DATA_WIDTH - 1)) begin
                            rx_state_q <= STOP;
                        end else begin
                            rx_idx_q <= rx_idx_q + 1'b1;
                        end
                    end
                end
                default: begin   // STOP
                    if (rx_tick_i) begin
                        rx_state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state_q == DATA && rx_tick_i) begin
            rx_shift_q <= {rx_s2_q, rx_shift_q[DATA_WIDTH-1:1]};
        end
    end

    assign rx_fall          = rx_prev_q && !rx_s2_q;
    assign rx_run_o         = (rx_state_q != IDLE);
    assign rx_timer_start_o = (rx_state_q == IDLE) && rx_fall;
    assign rx_half_o        = (rx_state_q == IDLE);   // First period lands mid start bit
    assign rx_done_o        = (rx_state_q == STOP) && rx_tick_i && rx_s2_q;
    assign rx_data_o        = rx_shift_q;

    a_tx_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n_i) (tx_state_q == IDLE) |-> tx_o);

endmodule

/* source/uart_peripheral.sv */
`timescale 1ns/10ps

module uart_peripheral (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 sel_i,
    input  logic                 offset_i,
    input  logic                 read_i,
    input  logic                 write_i,
    input  arch_defs_pkg::data_t data_i,
    input  logic                 rx_i,
    output arch_defs_pkg::data_t data_o,
    output logic                 tx_o
);
    import arch_defs_pkg::*;
    import uart_defs_pkg::*;

    logic  tx_start;
    logic  data_rd;
    logic  tx_busy;
    logic  tx_run;
    logic  tx_timer_start;
    logic  tx_tick;
    logic  rx_run;
    logic  rx_timer_start;
    logic  rx_half;
    logic  rx_tick;
    logic  rx_done;
    data_t rx_data;
    data_t rx_buf_q;
    logic  rx_valid_q;
    logic  rx_overrun_q;
    data_t status;
    data_t rd_data_q;

    assign tx_start = sel_i && write_i && (offset_i == UART_DATA_OFFSET);
    assign data_rd  = sel_i && read_i && (offset_i == UART_DATA_OFFSET);

    always_comb begin
        status                    = '0;
        status[STATUS_TX_BUSY]    = tx_busy;
        status[STATUS_RX_VALID]   = rx_valid_q;
        status[STATUS_RX_OVERRUN] = rx_overrun_q;
    end

    // Receive flags, a new frame wins over a clearing read
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rx_valid_q   <= 1'b0;
            rx_overrun_q <= 1'b0;
        end else if (rx_done) begin
            rx_valid_q   <= 1'b1;
            rx_overrun_q <= (rx_valid_q || rx_overrun_q) && !data_rd;
        end else if (data_rd) begin
            rx_valid_q   <= 1'b0;
            rx_overrun_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_buf_q <= rx_data;   // Overwrites an unread byte
        end
        rd_data_q <= (offset_i == UART_DATA_OFFSET) ? rx_buf_q : status;
    end

    assign data_o = rd_data_q;

    uart_fsm u_fsm (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .tx_start_i       (tx_start),
        .tx_data_i        (data_i),
        .tx_tick_i        (tx_tick),
        .rx_tick_i        (rx_tick),
        .rx_i             (rx_i),
        .tx_o             (tx_o),
        .tx_busy_o        (tx_busy),
        .tx_run_o         (tx_run),
        .tx_timer_start_o (tx_timer_start),
        .rx_run_o         (rx_run),
        .rx_timer_start_o (rx_timer_start),
        .rx_half_o        (rx_half),
        .rx_done_o        (rx_done),
        .rx_data_o        (rx_data)
    );

    baud_timer u_tx_timer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .run_i      (tx_run),
        .start_i    (tx_timer_start),
        .half_i     (1'b0),          // Transmit always uses whole bits
        .bit_tick_o (tx_tick)
    );

    baud_timer u_rx_timer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .run_i      (rx_run),
        .start_i    (rx_timer_start),
        .half_i     (rx_half),
        .bit_tick_o (rx_tick)
    );

endmodule

/* source/memory_system.sv */
`timescale 1ns/10ps

module memory_system (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  arch_defs_pkg::addr_t mem_address_i,
    input  arch_defs_pkg::data_t mem_data_i,
    input  logic                 mem_read_i,
    input  logic                 mem_write_i,
    input  logic                 uart_rx_i,
    output arch_defs_pkg::data_t mem_data_o,
    output arch_defs_pkg::data_t output_port_o,
    output logic                 uart_tx_o
);
    import arch_defs_pkg::*;

    typedef enum logic [2:0] {SEL_NONE, SEL_RAM, SEL_VRAM, SEL_ROM, SEL_UART} rd_sel_e;

    logic    ce_ram;
    logic    ce_vram;
    logic    ce_mmio;
    logic    ce_rom;
    logic    ce_uart;
    logic    ce_led;
    rd_sel_e rd_sel_q;
    data_t   ram_data;
    data_t   vram_data;
    data_t   rom_data;
    data_t   uart_data;
    data_t   led_q;

    // Region decode on the upper address bits
    assign ce_ram  = mem_address_i[ADDR_WIDTH-1:RAM_ADDR_BITS]
                     == RAM_BASE[ADDR_WIDTH-1:RAM_ADDR_BITS];
    assign ce_vram = mem_address_i[ADDR_WIDTH-1:VRAM_ADDR_BITS]
                     == VRAM_BASE[ADDR_WIDTH-1:VRAM_ADDR_BITS];
    assign ce_mmio = mem_address_i[ADDR_WIDTH-1:MMIO_ADDR_BITS]
                     == MMIO_BASE[ADDR_WIDTH-1:MMIO_ADDR_BITS];
    assign ce_rom  = mem_address_i[ADDR_WIDTH-1:ROM_ADDR_BITS]
                     == ROM_BASE[ADDR_WIDTH-1:ROM_ADDR_BITS];

    // UART at page offsets 0 and 1, LED port at its own offset
    assign ce_uart = ce_mmio && (mem_address_i[MMIO_ADDR_BITS-1:1] == '0);
    assign ce_led  = ce_mmio && (mem_address_i[MMIO_ADDR_BITS-1:0] == LED_OFFSET);

    // Region of the read in flight, matches the registered memory outputs
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_sel_q <= SEL_NONE;
        end else if (!mem_read_i) begin
            rd_sel_q <= SEL_NONE;
        end else if (ce_ram) begin
            rd_sel_q <= SEL_RAM;
        end else if (ce_vram) begin
            rd_sel_q <= SEL_VRAM;
        end else if (ce_rom) begin
            rd_sel_q <= SEL_ROM;
        end else if (ce_uart) begin
            rd_sel_q <= SEL_UART;
        end else begin
            rd_sel_q <= SEL_NONE;   // Unmapped
        end
    end

    always_comb begin
        case (rd_sel_q)
            SEL_RAM:  mem_data_o = ram_data;
            SEL_VRAM: mem_data_o = vram_data;
            SEL_ROM:  mem_data_o = rom_data;
            SEL_UART: mem_data_o = uart_data;
            default:  mem_data_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            led_q <= '0;
        end else if (mem_write_i && ce_led) begin
            led_q <= mem_data_i;
        end
    end

    assign output_port_o = led_q;

    sync_ram #(.ADDR_BITS(RAM_ADDR_BITS)) u_ram (
        .clk    (clk),
        .we_i   (mem_write_i && ce_ram),
        .addr_i (mem_address_i[RAM_ADDR_BITS-1:0]),
        .data_i (mem_data_i),
        .data_o (ram_data)
    );

    sync_ram #(.ADDR_BITS(VRAM_ADDR_BITS)) u_vram (
        .clk    (clk),
        .we_i   (mem_write_i && ce_vram),
        .addr_i (mem_address_i[VRAM_ADDR_BITS-1:0]),
        .data_i (mem_data_i),
        .data_o (vram_data)
    );

    boot_rom u_rom (
        .clk    (clk),
        .addr_i (mem_address_i[ROM_ADDR_BITS-1:0]),
        .data_o (rom_data)
    );

    uart_peripheral u_uart (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .sel_i    (ce_uart),
        .offset_i (mem_address_i[0]),
        .read_i   (mem_read_i),
        .write_i  (mem_write_i),
        .data_i   (mem_data_i),
        .rx_i     (uart_rx_i),
        .data_o   (uart_data),
        .tx_o     (uart_tx_o)
    );

    // Read and write strobes never share a cycle
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(mem_read_i && mem_write_i));

endmodule

/* tb/tb_memory_system.sv */
`timescale 1ns/10ps

module tb_memory_system;
    import arch_defs_pkg::*;

    localparam int    SEED        = 60136;
    localparam int    BIT_CLKS    = 8;         // Serial bit period in clocks
    localparam int    POLL_LIMIT  = 400;       // Status reads before a wait gives up
    localparam int    ROM_BYTES   = 4096;
    localparam string ROM_FILE    = "source/rom_image.hex";
    localparam addr_t UART_STATUS = 16'hE000;
    localparam addr_t UART_DATA   = 16'hE001;
    localparam addr_t LED_ADDR    = 16'hE002;

    logic  clk;
    logic  rst_n;
    addr_t mem_address;
    data_t mem_data_wr;
    logic  mem_read;
    logic  mem_write;
    logic  uart_rx;
    logic  uart_tx;
    data_t mem_data_rd;
    data_t output_port;
    logic  loopback;
    logic  rx_line;

    // Reference models
    data_t ram_model [addr_t];
    addr_t written_q [$];
    data_t rom_model [ROM_BYTES];
    data_t led_model;

    assign uart_rx = loopback ? uart_tx : rx_line;

    memory_system dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .mem_address_i (mem_address),
        .mem_data_i    (mem_data_wr),
        .mem_read_i    (mem_read),
        .mem_write_i   (mem_write),
        .uart_rx_i     (uart_rx),
        .mem_data_o    (mem_data_rd),
        .output_port_o (output_port),
        .uart_tx_o     (uart_tx)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t ns: %s expected %02h got %02h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t ns: %s expected %b got %b",
                                $time, name, expected, actual));
        end
    endtask

    // All bus tasks start and end 2 ns after a rising edge
    task automatic bus_write(input addr_t addr, input data_t data);
        mem_address = addr;
        mem_data_wr = data;
        mem_write   = 1'b1;
        @(posedge clk);
        #2;
        mem_write = 1'b0;
        check_data("mem_data_o without read", 8'h00, mem_data_rd);
    endtask

    task automatic bus_read(input addr_t addr, output data_t data);
        mem_address = addr;
        mem_read    = 1'b1;
        @(posedge clk);
        #2;
        mem_read = 1'b0;
        data     = mem_data_rd;   // One cycle latency
    endtask

    task automatic read_expect(input addr_t addr, input data_t expected);
        data_t data;
        bus_read(addr, data);
        check_data($sformatf("mem_data_o @%04h", addr), expected, data);
    endtask

    task automatic ram_write(input addr_t addr, input data_t data);
        bus_write(addr, data);
        if (!ram_model.exists(addr)) begin
            written_q.push_back(addr);
        end
        ram_model[addr] = data;
    endtask

    // RAM and video RAM bytes that share the low index bits of an address
    task automatic check_low_aliases(input addr_t addr);
        addr_t ram_addr;
        addr_t vram_addr;
        ram_addr  = addr & 16'h1FFF;
        vram_addr = (addr & 16'h0FFF) | 16'hD000;
        if (ram_model.exists(ram_addr)) begin
            read_expect(ram_addr, ram_model[ram_addr]);
        end
        if (ram_model.exists(vram_addr)) begin
            read_expect(vram_addr, ram_model[vram_addr]);
        end
    endtask

    task automatic wait_status(input int bit_pos, input logic level, input string what);
        data_t status;
        int    polls;
        polls = 0;
        bus_read(UART_STATUS, status);
        while (status[bit_pos] !== level) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                abort_run($sformatf("timeout: %s did not happen within %0d status reads",
                                    what, POLL_LIMIT));
            end
            bus_read(UART_STATUS, status);
        end
    endtask

    // Frame from the testbench side of the serial line
    task automatic drive_frame(input data_t data, input logic stop_level);
        logic [9:0] bits;
        bits = {stop_level, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line = bits[i];
            repeat (BIT_CLKS) @(posedge clk);
            #2;
        end
        rx_line = 1'b1;
    endtask

    task automatic load_rom_model();
        for (int i = 0; i < ROM_BYTES; i++) begin
            rom_model[i] = '0;
        end
        $readmemh(ROM_FILE, rom_model);
    endtask

    // Expected line level in bit slot n of an 8N1 frame
    function automatic logic frame_level(input data_t data, input int bit_no);
        if (bit_no == 0) begin
            return 1'b0;
        end
        if (bit_no <= 8) begin
            return data[bit_no-1];
        end
        return 1'b1;
    endfunction

    function automatic addr_t random_unmapped_addr();
        if ($urandom_range(0, 1) == 0) begin
            return addr_t'($urandom_range(16'h2000, 16'hCFFF));
        end
        return addr_t'($urandom_range(16'hE003, 16'hEFFF));   // Free MMIO offsets
    endfunction

    initial begin
        #1_000_000;
        abort_run("simulation time limit reached before the test sequence finished");
    end

    initial begin
        data_t rd;
        data_t b1;
        data_t b2;
        addr_t a;

        void'($urandom(SEED));
        clk         = 1'b0;
        rst_n       = 1'b0;
        mem_address = '0;
        mem_data_wr = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        loopback    = 1'b0;
        rx_line     = 1'b1;   // Idle line
        led_model   = '0;
        load_rom_model();

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_bit("uart_tx_o after reset", 1'b1, uart_tx);
        check_data("output_port_o after reset", 8'h00, output_port);
        read_expect(UART_STATUS, 8'h00);

        // RAM and video RAM traffic against one model
        for (int i = 0; i < 800; i++) begin
            if (written_q.size() == 0 || $urandom_range(0, 1) == 0) begin
                if ($urandom_range(0, 1) == 0) begin
                    a = addr_t'($urandom_range(16'h0000, 16'h1FFF));
                end else begin
                    a = addr_t'($urandom_range(16'hD000, 16'hDFFF));
                end
                ram_write(a, data_t'($urandom));
            end else begin
                a = written_q[$urandom_range(0, written_q.size() - 1)];
                read_expect(a, ram_model[a]);
            end
        end

        // Same low index in both RAMs
        for (int i = 0; i < 16; i++) begin
            a = addr_t'($urandom_range(16'h0000, 16'h0FFF));
            ram_write(a, data_t'($urandom));
            ram_write(a | 16'hD000, data_t'($urandom));
            read_expect(a, ram_model[a]);
            read_expect(a | 16'hD000, ram_model[a | 16'hD000]);
        end

        // ROM image, then random ROM reads with ignored writes
        for (int i = 0; i < 16; i++) begin
            read_expect(16'hF000 + addr_t'(i), rom_model[i]);
        end
        for (int i = 0; i < 64; i++) begin
            a = addr_t'($urandom_range(16'hF000, 16'hFFFF));
            if ($urandom_range(0, 1) == 0) begin
                bus_write(a, data_t'($urandom));
                check_low_aliases(a);
            end
            read_expect(a, rom_model[a[11:0]]);
        end

        for (int i = 0; i < 40; i++) begin
            a = random_unmapped_addr();
            bus_write(a, data_t'($urandom));
            read_expect(a, 8'h00);
            check_low_aliases(a);
        end
        check_data("output_port_o", led_model, output_port);

        // LED port
        for (int i = 0; i < 8; i++) begin
            led_model = data_t'($urandom);
            bus_write(LED_ADDR, led_model);
            check_data("output_port_o", led_model, output_port);
            if (i % 2 == 0) begin
                bus_write(UART_STATUS, data_t'($urandom));
            end else begin
                bus_write(addr_t'($urandom_range(16'hE003, 16'hEFFF)), data_t'($urandom));
            end
            check_data("output_port_o", led_model, output_port);
        end

        // Transmit frame timing, line checked every cycle
        b1 = data_t'($urandom);
        check_bit("uart_tx_o before frame", 1'b1, uart_tx);
        bus_write(UART_DATA, b1);
        for (int k = 0; k < 10 * BIT_CLKS; k++) begin
            check_bit($sformatf("uart_tx_o cycle %0d", k),
                      frame_level(b1, k / BIT_CLKS), uart_tx);
            bus_read(UART_STATUS, rd);
            check_bit("status tx_busy", 1'b1, rd[0]);
        end
        check_bit("uart_tx_o after stop", 1'b1, uart_tx);
        bus_read(UART_STATUS, rd);
        check_bit("status tx_busy", 1'b0, rd[0]);
        check_data("status upper bits", 8'h00, rd & 8'hF8);

        // Loopback, one frame then an overrun
        loopback = 1'b1;
        b1 = data_t'($urandom);
        bus_write(UART_DATA, b1);
        wait_status(1, 1'b1, "rx_valid after a looped frame");
        bus_read(UART_STATUS, rd);
        check_bit("status rx_overrun", 1'b0, rd[2]);
        read_expect(UART_DATA, b1);
        bus_read(UART_STATUS, rd);
        check_bit("status rx_valid", 1'b0, rd[1]);
        wait_status(0, 1'b0, "tx_busy clear after first frame");

        b1 = data_t'($urandom);
        b2 = data_t'($urandom);
        bus_write(UART_DATA, b1);
        wait_status(1, 1'b1, "rx_valid after the first of two frames");
        wait_status(0, 1'b0, "tx_busy clear between frames");
        bus_write(UART_DATA, b2);
        wait_status(2, 1'b1, "rx_overrun after a second unread frame");
        bus_read(UART_STATUS, rd);
        check_bit("status rx_valid", 1'b1, rd[1]);
        read_expect(UART_DATA, b2);   // Second byte replaces the first
        bus_read(UART_STATUS, rd);
        check_bit("status rx_valid", 1'b0, rd[1]);
        check_bit("status rx_overrun", 1'b0, rd[2]);
        wait_status(0, 1'b0, "tx_busy clear after second frame");
        loopback = 1'b0;

        // Frames driven by the testbench, the bad stop bit is dropped
        b1 = data_t'($urandom);
        drive_frame(b1, 1'b1);
        wait_status(1, 1'b1, "rx_valid after a driven frame");
        read_expect(UART_DATA, b1);
        drive_frame(data_t'($urandom), 1'b0);
        repeat (2 * BIT_CLKS) @(posedge clk);
        #2;
        bus_read(UART_STATUS, rd);
        check_bit("status rx_valid after bad stop bit", 1'b0, rd[1]);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* source/rom_image.hex */
// Boot ROM image, one byte per entry starting at F000
// Entries past the last byte read as zero
31 FF 1F 21
00 D0 3E 41
77 23 18 FB
C3 00 F0 76

/* tb.f */
source/arch_defs_pkg.sv
source/uart_defs_pkg.sv
source/sync_ram.sv
source/boot_rom.sv
source/baud_timer.sv
source/uart_fsm.sv
source/uart_peripheral.sv
source/memory_system.sv
tb/tb_memory_system.sv

/* Makefile */
# Verilator simulation of the memory system testbench

VERILATOR ?= verilator
TOP       ?= tb_memory_system
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f tb.f
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench passed" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
